/* bpu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Branch prediction unit shared definitions
// Address and index widths, table depth, 2-bit counter states and the
// helper functions used by the predictor and the resolver
////////////////////////////////////////////////////////////////////////////
package bpu_pkg;

  localparam int ADDR_W      = 16;             // Instruction address width
  localparam int IDX_W       = 3;              // Table index width, pc[3:1]
  localparam int TABLE_DEPTH = 1 << IDX_W;     // Entries per table

  // 2-bit saturating counter, msb is the predicted direction
  typedef enum logic [1:0] {
    BHT_SNT = 2'd0,                            // Strong not taken
    BHT_WNT = 2'd1,                            // Weak not taken
    BHT_WT  = 2'd2,                            // Weak taken
    BHT_ST  = 2'd3                             // Strong taken
  } bht_state_t;

  // Next counter state, one step toward the actual direction
  function automatic bht_state_t bht_next(input bht_state_t state, input logic taken);
    bht_state_t nxt;
    nxt = state;                               // Hold at the rails
    if (taken && (state != BHT_ST)) begin
      nxt = bht_state_t'(state + 2'd1);        // Step up
    end else if (!taken && (state != BHT_SNT)) begin
      nxt = bht_state_t'(state - 2'd1);        // Step down
    end
    return nxt;
  endfunction

  // Halfword aligned PCs, so bit 0 is skipped
  function automatic logic [IDX_W-1:0] table_index(input logic [ADDR_W-1:0] pc);
    return pc[IDX_W:1];
  endfunction

endpackage

/* bpu_update_if.sv */
////////////////////////////////////////////////////////////////////////////
// Table update bundle
// Carries the BHT and BTB write-back from the resolver to the predictor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface bpu_update_if import bpu_pkg::*; ();

  logic             bht_we;     // BHT write strobe, single cycle
  logic             btb_we;     // BTB write strobe, single cycle
  logic [IDX_W-1:0] index;      // Entry shared by both tables
  bht_state_t       bht_state;  // New counter value
  logic [ADDR_W-1:0] target;    // New branch target

  // Drive side, decode stage resolution
  modport resolver (
    output bht_we,
    output btb_we,
    output index,
    output bht_state,
    output target
  );

  // Receive side, the table storage
  modport predictor (
    input bht_we,
    input btb_we,
    input index,
    input bht_state,
    input target
  );

endinterface

/* fetch_pc_stage.sv */
////////////////////////////////////////////////////////////////////////////
// IF/ID prediction register
// Captures the fetch PC together with the prediction and target returned
// for it, so decode can check the guess made for each instruction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_pc_stage import bpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,           // Low stalls the register
  input  logic [ADDR_W-1:0] pc,               // Current fetch address
  input  bht_state_t        prediction,       // Counter read for pc
  input  logic [ADDR_W-1:0] predicted_target, // BTB target read for pc
  output logic [ADDR_W-1:0] if_pc,            // PC now in decode
  output bht_state_t        if_prediction,    // Counter carried with it
  output logic [ADDR_W-1:0] if_target         // Target carried with it
);

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////////////////////////////////////////
  // While the instruction held here resolves in decode, the next PC is
  // already being looked up by the predictor in the same cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      if_pc         <= '0;
      if_prediction <= BHT_SNT;              // Reads as not taken
      if_target     <= '0;
    end else if (enable) begin
      if_pc         <= pc;                   // Advance one instruction
      if_prediction <= prediction;
      if_target     <= predicted_target;
    end
    // Enable low holds all three fields
  end

endmodule

/* branch_predictor.sv */
////////////////////////////////////////////////////////////////////////////
// Branch history table and branch target buffer
// Eight 2-bit counters and eight 16-bit targets, read combinationally at
// the fetch PC and written from the resolver's update bundle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_predictor import bpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,           // Gates reads and writes
  input  logic [ADDR_W-1:0] pc,               // Fetch address to look up
  bpu_update_if.predictor   upd,              // Write-back from decode
  output bht_state_t        prediction,       // Counter at pc, 0 when stalled
  output logic [ADDR_W-1:0] predicted_target  // Target at pc, 0 when stalled
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage and control
  ////////////////////////////////////////////////////////////////////////////
  bht_state_t        bht_mem [TABLE_DEPTH];   // Direction counters
  logic [ADDR_W-1:0] btb_mem [TABLE_DEPTH];   // Branch targets

  logic [IDX_W-1:0]  rd_idx;                  // Lookup entry for pc
  logic              bht_wr;                  // Qualified BHT write
  logic              btb_wr;                  // Qualified BTB write

  assign rd_idx = table_index(pc);            // pc[3:1], aliases above bit 3

  // A stall blocks both writes, strobes alone are not enough
  assign bht_wr = enable & upd.bht_we;
  assign btb_wr = enable & upd.btb_we;

  ////////////////////////////////////////////////////////////////////////////
  // BHT
  ////////////////////////////////////////////////////////////////////////////
  // Only written on a mispredict, so a correct guess leaves the
  // counter where it is

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TABLE_DEPTH; i++) begin
        bht_mem[i] <= BHT_SNT;                // All entries strong not taken
      end
    end else if (bht_wr) begin
      bht_mem[upd.index] <= upd.bht_state;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // BTB
  ////////////////////////////////////////////////////////////////////////////
  // Written on every taken branch, keeps the latest target seen

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < TABLE_DEPTH; i++) begin
        btb_mem[i] <= '0;
      end
    end else if (btb_wr) begin
      btb_mem[upd.index] <= upd.target;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////
  // Asynchronous read of the registered arrays, so a write at this
  // edge shows up from the next cycle on

  always_comb begin
    if (enable) begin
      prediction       = bht_mem[rd_idx];
      predicted_target = btb_mem[rd_idx];
    end else begin
      prediction       = BHT_SNT;             // Stalled fetch sees zeros
      predicted_target = '0;
    end
  end

endmodule

/* branch_resolver.sv */
////////////////////////////////////////////////////////////////////////////
// Branch resolver
// Checks the decode outcome against the carried prediction, flags a
// mispredict, gives the corrected fetch address and the table update
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_resolver import bpu_pkg::*; (
  input  logic              enable,         // Low suppresses all results
  input  logic [ADDR_W-1:0] if_pc,          // PC of the instruction in decode
  input  bht_state_t        if_prediction,  // Counter used when it was fetched
  input  logic [ADDR_W-1:0] if_target,      // Target used when it was fetched
  input  logic              was_branch,     // Decode found a branch
  input  logic              actual_taken,   // Resolved direction
  input  logic [ADDR_W-1:0] actual_target,  // Resolved target
  output logic              mispredict,     // Fetch went the wrong way
  output logic [ADDR_W-1:0] redirect_pc,    // Where fetch should have gone
  bpu_update_if.resolver    upd             // Write-back to the tables
);

  ////////////////////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////////////////////
  logic pred_taken;                         // Guessed direction
  logic dir_wrong;                          // Direction mismatch
  logic tgt_wrong;                          // Right direction, stale target
  logic resolve;                            // Valid branch this cycle
  logic taken_br;                           // Branch really taken

  assign pred_taken = if_prediction[1];     // Counter msb
  assign resolve    = enable & was_branch;
  assign taken_br   = was_branch & actual_taken;

  assign dir_wrong  = (pred_taken != actual_taken);
  assign tgt_wrong  = actual_taken & pred_taken & (if_target != actual_target);

  assign mispredict = resolve & (dir_wrong | tgt_wrong);

  // Taken goes to the real target, anything else falls through
  assign redirect_pc = taken_br ? actual_target : (if_pc + ADDR_W'(2));

  ////////////////////////////////////////////////////////////////////////////
  // Table update
  ////////////////////////////////////////////////////////////////////////////
  // Lands at the next rising edge in the predictor

  assign upd.index     = table_index(if_pc);
  assign upd.bht_we    = mispredict;                          // Train on misses only
  assign upd.bht_state = bht_next(if_prediction, actual_taken);
  assign upd.btb_we    = enable & taken_br;                   // Every taken branch
  assign upd.target    = actual_target;

endmodule

/* bpu_top.sv */
////////////////////////////////////////////////////////////////////////////
// Branch prediction unit top level
// Fetch lookup, IF/ID prediction register and decode resolver, with the
// table write-back looping from resolver to predictor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_top import bpu_pkg::*; (
  input  logic              clk,
  input  logic              rst,              // Synchronous, active high
  input  logic              enable,           // Low acts as a stall
  input  logic [ADDR_W-1:0] pc,               // Fetch address
  input  logic              was_branch,       // Decode: instruction is a branch
  input  logic              actual_taken,     // Decode: resolved direction
  input  logic [ADDR_W-1:0] actual_target,    // Decode: resolved target
  output bht_state_t        prediction,       // Counter for pc, same cycle
  output logic [ADDR_W-1:0] predicted_target, // Target for pc, same cycle
  output logic              mispredict,       // Decode found a wrong guess
  output logic [ADDR_W-1:0] redirect_pc       // Corrected fetch address
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////////////////////
  logic [ADDR_W-1:0] if_pc;                   // IF/ID copy of pc
  bht_state_t        if_prediction;           // IF/ID copy of prediction
  logic [ADDR_W-1:0] if_target;               // IF/ID copy of target

  bpu_update_if upd_if ();                    // Resolver to predictor writes

  ////////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////////

  // Lookup at the fetch PC
  branch_predictor predictor_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc               (pc),
    .upd              (upd_if.predictor),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

  // Carry the guess into decode
  fetch_pc_stage fetch_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc               (pc),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .if_pc            (if_pc),
    .if_prediction    (if_prediction),
    .if_target        (if_target)
  );

  // Check it against the real outcome
  branch_resolver resolver_i (
    .enable           (enable),
    .if_pc            (if_pc),
    .if_prediction    (if_prediction),
    .if_target        (if_target),
    .was_branch       (was_branch),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .mispredict       (mispredict),
    .redirect_pc      (redirect_pc),
    .upd              (upd_if.resolver)
  );

endmodule

/* bpu_tb_model.svh */
////////////////////////////////////////////////////////////////////////////
// Reference model of the branch prediction unit
// Mirrors the BHT, BTB and IF/ID register and derives the expected fetch
// and decode outputs from the table rules
////////////////////////////////////////////////////////////////////////////
`ifndef BPU_TB_MODEL_SVH
`define BPU_TB_MODEL_SVH

  // Expected outputs for one cycle
  typedef struct packed {
    logic [1:0]  pred;                      // Counter read at pc
    logic [15:0] tgt;                       // Target read at pc
    logic        misp;                      // Wrong guess in decode
    logic [15:0] redir;                     // Corrected fetch address
  } expect_t;

  logic [1:0]  m_bht [8];                   // Model direction counters
  logic [15:0] m_btb [8];                   // Model targets
  logic [15:0] m_if_pc;                     // Model IF/ID register
  logic [1:0]  m_if_pred;
  logic [15:0] m_if_tgt;

  // 2-bit saturating count toward the actual direction
  function automatic logic [1:0] counter_step(input logic [1:0] cnt, input logic taken);
    logic [1:0] res;
    res = cnt;
    if (taken && cnt != 2'd3) res = cnt + 2'd1;
    if (!taken && cnt != 2'd0) res = cnt - 2'd1;
    return res;
  endfunction

  // Outputs for the current inputs and the model state
  function automatic expect_t expected_outputs(input logic en, input logic [15:0] fpc,
                                               input logic wb, input logic tk,
                                               input logic [15:0] atgt);
    expect_t    e;
    logic [2:0] idx;
    logic       guess;
    idx     = fpc[3:1];                     // Bit 0 and bits above 3 alias
    e.pred  = en ? m_bht[idx] : 2'd0;       // Stall reads zero
    e.tgt   = en ? m_btb[idx] : 16'h0;
    guess   = m_if_pred[1];                 // Taken when counter >= 2
    e.misp  = en && wb && ((guess != tk) || (tk && guess && (m_if_tgt != atgt)));
    e.redir = (wb && tk) ? atgt : m_if_pc + 16'd2;
    return e;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < 8; i++) begin
      m_bht[i] = 2'd0;
      m_btb[i] = 16'h0;
    end
    m_if_pc   = 16'h0;
    m_if_pred = 2'd0;
    m_if_tgt  = 16'h0;
  endtask

  // One enabled rising edge: table writes, then IF/ID capture
  task automatic advance_model(input logic en, input logic [15:0] fpc, input logic wb,
                               input logic tk, input logic [15:0] atgt);
    expect_t    e;
    logic [2:0] widx;
    e    = expected_outputs(en, fpc, wb, tk, atgt);   // Reads see old tables
    widx = m_if_pc[3:1];
    if (en) begin
      if (e.misp) m_bht[widx] = counter_step(m_if_pred, tk);   // Train on misses
      if (wb && tk) m_btb[widx] = atgt;                         // Every taken branch
      m_if_pc   = fpc;
      m_if_pred = e.pred;
      m_if_tgt  = e.tgt;
    end
  endtask

`endif

/* bpu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Branch prediction unit testbench
// Directed training, redirect, aliasing and stall tests plus a random run
// with every cycle compared against the reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bpu_tb import bpu_pkg::*; ();

  localparam int          CLK_HALF       = 4;              // 8 ns period
  localparam int          RESET_CYCLES   = 16;
  localparam int          RANDOM_CYCLES  = 300;
  localparam int          TIMEOUT_CYCLES = 2000;           // Whole run bound
  localparam logic [31:0] LFSR_SEED      = 32'd89202;
  localparam logic [31:0] LFSR_MASK      = 32'hA300_0000;  // Taps 32 30 26 25

  logic              clk;
  logic              rst;
  logic              enable;
  logic [ADDR_W-1:0] pc;
  logic              was_branch;
  logic              actual_taken;
  logic [ADDR_W-1:0] actual_target;
  logic [1:0]        prediction;
  logic [ADDR_W-1:0] predicted_target;
  logic              mispredict;
  logic [ADDR_W-1:0] redirect_pc;

  string       cur_test;                    // Name used in error lines
  int          test_errs;
  int          n_pass;
  int          n_fail;
  logic        check_en;                    // Compare process armed
  logic [31:0] lfsr_state;

  `include "bpu_tb_model.svh"

  expect_t cmp_exp;                         // Expected values at sample point

  bpu_top dut_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .pc               (pc),
    .was_branch       (was_branch),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .mispredict       (mispredict),
    .redirect_pc      (redirect_pc)
  );

  always #(CLK_HALF) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v          = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s %s expected 0x%h actual 0x%h", cur_test, what, exp, act);
      test_errs++;
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    $display("%-9s done, %0d errors", cur_test, test_errs);
  endtask

  task automatic drive_inputs(input logic en, input logic [15:0] fpc, input logic wb,
                              input logic tk, input logic [15:0] atgt);
    enable        = en;
    pc            = fpc;
    was_branch    = wb;
    actual_taken  = tk;
    actual_target = atgt;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                     // Drive point after the edge
  endtask

  // Plain fetch at pc with no branch in decode
  task automatic read_entry(input logic [15:0] fpc, input logic [1:0] exp_pred,
                            input logic [15:0] exp_tgt);
    drive_inputs(1'b1, fpc, 1'b0, 1'b0, 16'h0);
    #5;
    check_value("prediction", exp_pred, prediction);
    check_value("predicted_target", exp_tgt, predicted_target);
    next_cycle();
  endtask

  // Fetch bpc and resolve it in decode the next cycle
  task automatic resolve_branch(input logic [15:0] bpc, input logic tk,
                                input logic [15:0] tgt, input logic [1:0] exp_pred,
                                input logic [15:0] exp_tgt, input logic exp_misp,
                                input logic [15:0] exp_redir);
    read_entry(bpc, exp_pred, exp_tgt);
    drive_inputs(1'b1, bpc ^ 16'h0008, 1'b1, tk, tgt);   // Filler fetch from another entry
    #5;
    check_value("mispredict", exp_misp, mispredict);
    check_value("redirect_pc", exp_redir, redirect_pc);
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare
  ////////////////////////////////////////////////////////////////////////////
  // Inputs change 1 ns after the edge, so the model sees this cycle's values
  always @(posedge clk) begin
    if (rst) model_reset();
    else advance_model(enable, pc, was_branch, actual_taken, actual_target);
  end

  always begin
    @(posedge clk);
    #(2 * CLK_HALF - 1);                    // 1 ns before the next edge
    if (check_en) begin
      cmp_exp = expected_outputs(enable, pc, was_branch, actual_taken, actual_target);
      check_value("model prediction", cmp_exp.pred, prediction);
      check_value("model predicted_target", cmp_exp.tgt, predicted_target);
      check_value("model mispredict", cmp_exp.misp, mispredict);
      check_value("model redirect_pc", cmp_exp.redir, redirect_pc);
    end
  end

  initial begin
    for (int c = 0; c < TIMEOUT_CYCLES; c++) @(posedge clk);
    $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] r_en;
    logic [15:0] r_lo;
    logic [15:0] r_hi;
    logic [15:0] r_wb;
    logic [15:0] r_tk;
    logic [15:0] r_sel;
    clk        = 1'b0;
    rst        = 1'b1;
    drive_inputs(1'b0, 16'h0, 1'b0, 1'b0, 16'h0);
    check_en   = 1'b0;
    n_pass     = 0;
    n_fail     = 0;
    lfsr_state = LFSR_SEED;
    start_test("reset");
    for (int c = 0; c < RESET_CYCLES; c++) @(posedge clk);
    #1;
    rst      = 1'b0;
    check_en = 1'b1;

    // Cleared tables while decode sees a taken outcome without a branch
    for (int i = 0; i < 16; i++) begin
      drive_inputs(1'b1, 16'(i * 16'h1111), 1'b0, 1'b1, 16'h5A5A);
      #5;
      check_value("prediction", 16'h0, prediction);
      check_value("predicted_target", 16'h0, predicted_target);
      check_value("mispredict", 16'h0, mispredict);
      next_cycle();
    end
    finish_test();

    // Counter climbs on misses only and the first taken fills the BTB
    start_test("training");
    resolve_branch(16'h0040, 1'b1, 16'h0800, 2'd0, 16'h0000, 1'b1, 16'h0800);
    resolve_branch(16'h0040, 1'b1, 16'h0800, 2'd1, 16'h0800, 1'b1, 16'h0800);
    resolve_branch(16'h0040, 1'b1, 16'h0800, 2'd2, 16'h0800, 1'b0, 16'h0800);
    resolve_branch(16'h0040, 1'b1, 16'h0800, 2'd2, 16'h0800, 1'b0, 16'h0800);
    resolve_branch(16'h0040, 1'b0, 16'h0800, 2'd2, 16'h0800, 1'b1, 16'h0042);
    resolve_branch(16'h0040, 1'b0, 16'h0800, 2'd1, 16'h0800, 1'b0, 16'h0042);
    resolve_branch(16'h0040, 1'b0, 16'h0800, 2'd1, 16'h0800, 1'b0, 16'h0042);
    finish_test();

    // Direction misses and a stale target before a correct guess
    start_test("redirect");
    resolve_branch(16'h0104, 1'b1, 16'h2220, 2'd0, 16'h0000, 1'b1, 16'h2220);
    resolve_branch(16'h0104, 1'b1, 16'h2220, 2'd1, 16'h2220, 1'b1, 16'h2220);
    resolve_branch(16'h0104, 1'b0, 16'h2220, 2'd2, 16'h2220, 1'b1, 16'h0106);
    resolve_branch(16'h0104, 1'b1, 16'h2220, 2'd1, 16'h2220, 1'b1, 16'h2220);
    resolve_branch(16'h0104, 1'b1, 16'h3330, 2'd2, 16'h2220, 1'b1, 16'h3330);
    resolve_branch(16'h0104, 1'b1, 16'h3330, 2'd3, 16'h3330, 1'b0, 16'h3330);
    resolve_branch(16'h0104, 1'b0, 16'h3330, 2'd3, 16'h3330, 1'b1, 16'h0106);
    resolve_branch(16'h0104, 1'b1, 16'h3330, 2'd2, 16'h3330, 1'b0, 16'h3330);
    finish_test();

    // Entry 5 trained through one PC and read through its aliases
    start_test("aliasing");
    resolve_branch(16'h000A, 1'b1, 16'h4444, 2'd0, 16'h0000, 1'b1, 16'h4444);
    resolve_branch(16'h000A, 1'b1, 16'h4444, 2'd1, 16'h4444, 1'b1, 16'h4444);
    read_entry(16'h000B, 2'd2, 16'h4444);   // Bit 0 differs
    read_entry(16'h001A, 2'd2, 16'h4444);   // Bit 4 differs
    read_entry(16'hF00A, 2'd2, 16'h4444);   // Upper nibble differs
    finish_test();

    // Stalled taken branch must not write anything
    start_test("stall");
    for (int i = 0; i < 3; i++) begin
      drive_inputs(1'b0, 16'h000A, 1'b1, 1'b1, 16'h5555);
      #5;
      check_value("prediction", 16'h0, prediction);
      check_value("predicted_target", 16'h0, predicted_target);
      check_value("mispredict", 16'h0, mispredict);
      next_cycle();
    end
    read_entry(16'h000A, 2'd2, 16'h4444);
    read_entry(16'hF00A, 2'd2, 16'h4444);
    finish_test();

    // Model compare only with small pc and target sets so entries repeat
    start_test("random");
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      r_en  = take_bits(3);                 // Enable 7 of 8 cycles
      r_lo  = take_bits(6);
      r_hi  = take_bits(2);
      r_wb  = take_bits(1);
      r_tk  = take_bits(1);
      r_sel = take_bits(2);
      drive_inputs(r_en != 16'h0, {r_hi[1:0], 8'h00, r_lo[5:0]}, r_wb[0], r_tk[0],
                   {6'b000100, r_sel[1:0], 8'h00});
      next_cycle();
    end
    finish_test();

    check_en = 1'b0;
    $display("Checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* bpu_top.f */
+incdir+.
bpu_pkg.sv
bpu_update_if.sv
fetch_pc_stage.sv
branch_predictor.sv
branch_resolver.sv
bpu_top.sv
bpu_tb.sv
